// ==== rtl/tetrisPkg.sv ====
package tetrisPkg;

    //////////////////////////////////////////////////////////////////////
    // board geometry
    //////////////////////////////////////////////////////////////////////
    localparam int boardCols = 10;
    localparam int boardRows = 20;

    typedef logic [3:0] colIdx;
    typedef logic [4:0] rowIdx;

    // bit 0 is the leftmost column
    typedef logic [boardCols-1:0] boardRow;

    // 2x4 box, bits 0..3 top row left to right, bits 4..7 bottom row
    typedef logic [7:0] pieceShape;

    //////////////////////////////////////////////////////////////////////
    // shapes and spawn
    //////////////////////////////////////////////////////////////////////
    localparam int shapeCount = 7;

    // order I, T, O, S, Z, L, J
    localparam pieceShape shapeTable [shapeCount] = '{
        8'b0000_1111,
        8'b0111_0010,
        8'b0011_0011,
        8'b0011_0110,
        8'b0110_0011,
        8'b0001_0111,
        8'b0111_0001
    };

    localparam colIdx spawnCol = 4'd3;
    localparam rowIdx spawnRow = 5'd0;

    // gravity
    localparam int gravityPeriodDefault = 25_000_000;
    localparam int timerWidth = 25;

endpackage

// ==== rtl/gravityTimer.sv ====
`timescale 1ns/10ps

module gravityTimer import tetrisPkg::*; #(
    parameter int gravityPeriod = gravityPeriodDefault
) (
    input  logic clk,
    input  logic rst_up,
    input  logic run,
    input  logic fastFall,
    input  logic halt,
    input  logic tickTaken,
    output logic tick
);

    logic [timerWidth-1:0] dropCount;
    logic [timerWidth:0]   countNext;

    // fast fall steps by two
    assign countNext = dropCount + (fastFall ? 2 : 1);

    always_ff @(posedge clk) begin
        if (rst_up) begin
            dropCount <= '0;
            tick      <= 1'b0;
        end else if (tickTaken) begin
            tick <= 1'b0;
        end else if (run && !halt && !tick) begin
            if (countNext >= gravityPeriod) begin
                dropCount <= '0;
                tick      <= 1'b1;
            end else begin
                dropCount <= countNext[timerWidth-1:0];
            end
        end
    end

    // the controller only takes a tick that is pending
    tickTakenOnlyWhenPending: assert property (
        @(posedge clk) disable iff (rst_up) tickTaken |-> tick
    );

endmodule

// ==== rtl/pieceSequencer.sv ====
`timescale 1ns/10ps

module pieceSequencer import tetrisPkg::*; (
    input  logic      clk,
    input  logic      rst_up,
    input  logic      advance,
    output pieceShape nextShape
);

    logic [2:0] shapeIndex;

    // entry 0 is already the first live piece
    always_ff @(posedge clk) begin
        if (rst_up) begin
            shapeIndex <= 3'd1;
        end else if (advance) begin
            if (shapeIndex == 3'(shapeCount - 1)) begin
                shapeIndex <= 3'd0;
            end else begin
                shapeIndex <= shapeIndex + 3'd1;
            end
        end
    end

    assign nextShape = shapeTable[shapeIndex];

    indexInRange: assert property (
        @(posedge clk) disable iff (rst_up) shapeIndex < 3'(shapeCount)
    );

endmodule

// ==== rtl/gameControl.sv ====
`timescale 1ns/10ps

module gameControl import tetrisPkg::*; (
    input  logic      clk,
    input  logic      rst_up,
    input  logic      moveLeft,
    input  logic      moveRight,
    input  logic      tick,
    input  logic      probeHit,
    input  logic      compactDone,
    input  pieceShape nextShape,
    output logic      tickTaken,
    output logic      lockPiece,
    output logic      advance,
    output logic      ready,
    output logic      gameOver,
    output colIdx     probeCol,
    output rowIdx     probeRow,
    output pieceShape probeShape,
    output colIdx     pieceCol,
    output rowIdx     pieceRow,
    output pieceShape pieceShapeNow
);

    typedef enum logic [2:0] {
        idle,
        probe,
        commit,
        lock,
        compact,
        spawnProbe,
        over
    } ctrlState;

    ctrlState state;
    logic     pendingDrop;
    logic     hitLatched;

    assign ready      = (state == idle);
    assign gameOver   = (state == over);
    assign lockPiece  = (state == lock);
    assign advance    = (state == compact) && compactDone;
    // moves beat a pending tick
    assign tickTaken  = ready && tick && !moveLeft && !moveRight;
    assign probeShape = pieceShapeNow;

    //////////////////////////////////////////////////////////////////////
    // state machine and live piece
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst_up) begin
            state         <= idle;
            pieceCol      <= spawnCol;
            pieceRow      <= spawnRow;
            pieceShapeNow <= shapeTable[0];
            probeCol      <= spawnCol;
            probeRow      <= spawnRow;
        end else begin
            case (state)
                idle: begin
                    if (moveLeft || moveRight) begin
                        // left wins when both arrive
                        probeCol    <= moveLeft ? pieceCol - 4'd1 : pieceCol + 4'd1;
                        probeRow    <= pieceRow;
                        pendingDrop <= 1'b0;
                        state       <= probe;
                    end else if (tick) begin
                        probeCol    <= pieceCol;
                        probeRow    <= pieceRow + 5'd1;
                        pendingDrop <= 1'b1;
                        state       <= probe;
                    end
                end
                probe: begin
                    hitLatched <= probeHit;
                    state      <= commit;
                end
                commit: begin
                    if (hitLatched) begin
                        // blocked drop means landing
                        state <= pendingDrop ? lock : idle;
                    end else begin
                        pieceCol <= probeCol;
                        pieceRow <= probeRow;
                        state    <= idle;
                    end
                end
                lock: begin
                    state <= compact;
                end
                compact: begin
                    if (compactDone) begin
                        pieceShapeNow <= nextShape;
                        pieceCol      <= spawnCol;
                        pieceRow      <= spawnRow;
                        probeCol      <= spawnCol;
                        probeRow      <= spawnRow;
                        state         <= spawnProbe;
                    end
                end
                spawnProbe: begin
                    state <= probeHit ? over : idle;
                end
                default: begin
                    // over holds until reset
                    state <= over;
                end
            endcase
        end
    end

    // ready stays low through the lock and the whole compaction pass
    noReadyDuringLock: assert property (
        @(posedge clk) disable iff (rst_up)
        lockPiece |-> !ready ##1 (!ready)[*boardRows]
    );

endmodule

// ==== rtl/playfield.sv ====
`timescale 1ns/10ps

module playfield import tetrisPkg::*; (
    input  logic      clk,
    input  logic      rst_up,
    input  colIdx     probeCol,
    input  colIdx     pieceCol,
    input  rowIdx     probeRow,
    input  rowIdx     pieceRow,
    input  rowIdx     rowSel,
    input  pieceShape probeShape,
    input  pieceShape pieceShapeNow,
    input  logic      lockPiece,
    output logic      probeHit,
    output logic      compactDone,
    output boardRow   rowData
);

    boardRow locked [boardRows];

    logic              busy;
    rowIdx             wrPtr;
    logic signed [5:0] rdPtr;
    logic signed [5:0] srcIdx;
    boardRow           srcRow;
    boardRow           liveRow;

    //////////////////////////////////////////////////////////////////////
    // collision probe
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        int r;
        int c;
        probeHit = 1'b0;
        for (int b = 0; b < 8; b++) begin
            r = int'(probeRow) + b / 4;
            c = int'(probeCol) + b % 4;
            if (probeShape[b]) begin
                if (r >= boardRows || c >= boardCols) begin
                    probeHit = 1'b1;
                end else if (locked[r][c]) begin
                    probeHit = 1'b1;
                end
            end
        end
    end

    // next source row, a lock fills at most two rows
    always_comb begin
        srcIdx = rdPtr;
        for (int s = 0; s < 2; s++) begin
            if (srcIdx >= 0 && (&locked[srcIdx[4:0]])) begin
                srcIdx = srcIdx - 6'sd1;
            end
        end
        srcRow = (srcIdx >= 0) ? locked[srcIdx[4:0]] : '0;
    end

    assign compactDone = busy && (wrPtr == 5'd0);

    //////////////////////////////////////////////////////////////////////
    // lock and compaction
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        int r;
        int c;
        if (rst_up) begin
            for (int i = 0; i < boardRows; i++) begin
                locked[i] <= '0;
            end
            busy  <= 1'b0;
            wrPtr <= 5'(boardRows - 1);
            rdPtr <= 6'(boardRows - 1);
        end else if (lockPiece) begin
            for (int b = 0; b < 8; b++) begin
                r = int'(pieceRow) + b / 4;
                c = int'(pieceCol) + b % 4;
                if (pieceShapeNow[b] && r < boardRows && c < boardCols) begin
                    locked[r][c] <= 1'b1;
                end
            end
            busy  <= 1'b1;
            wrPtr <= 5'(boardRows - 1);
            rdPtr <= 6'(boardRows - 1);
        end else if (busy) begin
            // one destination row per cycle, bottom up
            locked[wrPtr] <= srcRow;
            rdPtr         <= srcIdx - 6'sd1;
            wrPtr         <= wrPtr - 5'd1;
            if (wrPtr == 5'd0) begin
                busy <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // row read port with the live piece merged in
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        int c;
        liveRow = '0;
        for (int b = 0; b < 8; b++) begin
            c = int'(pieceCol) + b % 4;
            if (pieceShapeNow[b] && (int'(pieceRow) + b / 4 == int'(rowSel))
                && c < boardCols) begin
                liveRow[c] = 1'b1;
            end
        end
    end

    assign rowData = (int'(rowSel) < boardRows) ? (locked[rowSel] | liveRow) : '0;

endmodule

// ==== rtl/tetrisTop.sv ====
`timescale 1ns/10ps

module tetrisTop import tetrisPkg::*; #(
    parameter int gravityPeriod = gravityPeriodDefault
) (
    input  logic    clk,
    input  logic    rst_up,
    input  logic    run,
    input  logic    fastFall,
    input  logic    moveLeft,
    input  logic    moveRight,
    input  rowIdx   rowSel,
    output logic    ready,
    output logic    gameOver,
    output boardRow rowData
);

    logic      tick;
    logic      tickTaken;
    logic      probeHit;
    logic      compactDone;
    logic      lockPiece;
    logic      advance;
    pieceShape nextShape;
    colIdx     probeCol;
    rowIdx     probeRow;
    pieceShape probeShape;
    colIdx     pieceCol;
    rowIdx     pieceRow;
    pieceShape pieceShapeNow;

    gravityTimer #(.gravityPeriod(gravityPeriod)) timer (
        .clk(clk), .rst_up(rst_up), .run(run), .fastFall(fastFall),
        .halt(gameOver), .tickTaken(tickTaken), .tick(tick)
    );

    pieceSequencer sequencer (
        .clk(clk), .rst_up(rst_up), .advance(advance), .nextShape(nextShape)
    );

    // controller drives the probe and the live piece
    gameControl control (
        .clk(clk), .rst_up(rst_up), .moveLeft(moveLeft), .moveRight(moveRight),
        .tick(tick), .probeHit(probeHit), .compactDone(compactDone),
        .nextShape(nextShape), .tickTaken(tickTaken), .lockPiece(lockPiece),
        .advance(advance), .ready(ready), .gameOver(gameOver),
        .probeCol(probeCol), .probeRow(probeRow), .probeShape(probeShape),
        .pieceCol(pieceCol), .pieceRow(pieceRow), .pieceShapeNow(pieceShapeNow)
    );

    playfield board (
        .clk(clk), .rst_up(rst_up), .probeCol(probeCol), .pieceCol(pieceCol),
        .probeRow(probeRow), .pieceRow(pieceRow), .rowSel(rowSel),
        .probeShape(probeShape), .pieceShapeNow(pieceShapeNow),
        .lockPiece(lockPiece), .probeHit(probeHit), .compactDone(compactDone),
        .rowData(rowData)
    );

endmodule

// ==== tb/tetrisModel.svh ====
//////////////////////////////////////////////////////////////////////
// reference game model
//////////////////////////////////////////////////////////////////////
logic [9:0] refBoard [20];
logic [7:0] refShape;
int         refCol;
int         refRow;
int         refSeq;
int         refLines;
bit         refOver;

// I, T, O, S, Z, L, J with bit 0 the top left cell, bits 4..7 the bottom row
localparam logic [7:0] refShapes [7] = '{
    8'b0000_1111, 8'b0111_0010, 8'b0011_0011, 8'b0011_0110,
    8'b0110_0011, 8'b0001_0111, 8'b0111_0001
};

function automatic bit refHits(int col, int row, logic [7:0] shp);
    int r;
    int c;
    for (int b = 0; b < 8; b++) begin
        r = row + b / 4;
        c = col + b % 4;
        if (shp[b]) begin
            if (c < 0 || c >= 10 || r >= 20) return 1'b1;
            if (refBoard[r][c]) return 1'b1;
        end
    end
    return 1'b0;
endfunction

function automatic void refSpawn();
    refShape = refShapes[refSeq];
    refSeq = (refSeq + 1) % 7;
    refCol = 3;
    refRow = 0;
    refOver = refHits(refCol, refRow, refShape);
endfunction

function automatic void refReset();
    for (int i = 0; i < 20; i++) refBoard[i] = '0;
    refShape = refShapes[0];
    refSeq = 1;
    refCol = 3;
    refRow = 0;
    refLines = 0;
    refOver = 1'b0;
endfunction

function automatic void refMove(bit left);
    int newCol;
    newCol = left ? refCol - 1 : refCol + 1;
    if (!refHits(newCol, refRow, refShape)) refCol = newCol;
endfunction

// full rows vanish, everything above slides down
function automatic void refCompact();
    logic [9:0] kept [20];
    int dst;
    dst = 19;
    for (int i = 0; i < 20; i++) kept[i] = '0;
    for (int src = 19; src >= 0; src--) begin
        if (&refBoard[src]) begin
            refLines++;
        end else begin
            kept[dst] = refBoard[src];
            dst--;
        end
    end
    for (int i = 0; i < 20; i++) refBoard[i] = kept[i];
endfunction

// one gravity step, returns 1 when the piece landed
function automatic bit refTick();
    if (!refHits(refCol, refRow + 1, refShape)) begin
        refRow++;
        return 1'b0;
    end
    for (int b = 0; b < 8; b++) begin
        if (refShape[b] && refRow + b / 4 < 20 && refCol + b % 4 < 10) begin
            refBoard[refRow + b / 4][refCol + b % 4] = 1'b1;
        end
    end
    refCompact();
    refSpawn();
    return 1'b1;
endfunction

function automatic logic [9:0] expectedRow(int row);
    logic [9:0] value;
    value = refBoard[row];
    for (int b = 0; b < 8; b++) begin
        if (refShape[b] && refRow + b / 4 == row && refCol + b % 4 < 10) begin
            value[refCol + b % 4] = 1'b1;
        end
    end
    return value;
endfunction

// ==== tb/tetrisTb.sv ====
`timescale 1ns/10ps

module tetrisTb;

    logic       clk;
    logic       rst_up;
    logic       run;
    logic       fastFall;
    logic       moveLeft;
    logic       moveRight;
    logic [4:0] rowSel;
    logic       ready;
    logic       gameOver;
    logic [9:0] rowData;

    int errorCount;
    int checkCount;
    int sweepErrors;
    int sweepChecks;
    int testCount;
    int testsFailed;
    int checksAsked;
    int checksDone;

    `include "tetrisModel.svh"

    tetrisTop #(.gravityPeriod(64)) UUT (
        .clk(clk), .rst_up(rst_up), .run(run), .fastFall(fastFall),
        .moveLeft(moveLeft), .moveRight(moveRight), .rowSel(rowSel),
        .ready(ready), .gameOver(gameOver), .rowData(rowData)
    );

    always #4 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // board comparison against the model
    //////////////////////////////////////////////////////////////////////
    initial begin
        rowSel = '0;
        forever begin
            @(posedge clk);
            if (checksDone < checksAsked) begin
                for (int r = 0; r < 20; r++) begin
                    @(posedge clk);
                    #1 rowSel = 5'(r);
                    #2 sweepChecks++;
                    if (rowData !== expectedRow(r)) begin
                        $display("CHECK FAILED at %0t: rowData row %0d got %b expected %b",
                                 $time, r, rowData, expectedRow(r));
                        sweepErrors++;
                    end
                end
                checksDone++;
            end
        end
    end

    task automatic checkValue(string name, int got, int expected);
        checkCount++;
        if (got != expected) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, expected);
            errorCount++;
        end
    endtask

    task automatic reportProblem(string what);
        $display("ERROR at %0t: %s", $time, what);
        errorCount++;
    endtask

    task automatic sweepBoard();
        int waited;
        waited = 0;
        checksAsked++;
        while (checksDone != checksAsked && waited < 100) begin
            @(posedge clk);
            #1 waited++;
        end
        if (checksDone != checksAsked) reportProblem("board sweep did not finish");
    endtask

    task automatic waitReadyHigh(output int lowCycles);
        lowCycles = 0;
        while (!ready && !gameOver && lowCycles < 200) begin
            @(posedge clk);
            #1 lowCycles++;
        end
        if (!ready && !gameOver) reportProblem("ready never came back");
    endtask

    task automatic waitReadyLow(output int waited);
        waited = 0;
        while (ready && waited < 300) begin
            @(posedge clk);
            #1 waited++;
        end
        if (ready) reportProblem("no gravity tick was taken");
    endtask

    task automatic issueMove(bit left);
        int lowCycles;
        moveLeft = left;
        moveRight = !left;
        @(posedge clk);
        #1 moveLeft = 1'b0;
        moveRight = 1'b0;
        refMove(left);
        checkValue("ready", ready, 0);
        waitReadyHigh(lowCycles);
        checkValue("ready low cycles", lowCycles, 2);
        sweepBoard();
    endtask

    // run drops again once the tick is taken
    task automatic dropEpisode(output bit landed);
        int lowCycles;
        int tickCycles;
        run = 1'b1;
        waitReadyLow(tickCycles);
        run = 1'b0;
        // period edges up to the tick, one more edge to take it
        checkValue("cycles to tick", tickCycles, fastFall ? 64 / 2 + 1 : 64 + 1);
        landed = refTick();
        waitReadyHigh(lowCycles);
        if (landed) begin
            // probe and commit, lock, one compaction cycle per row and the spawn probe
            checkValue("landing low cycles", lowCycles, 3 + 20 + 1);
        end else begin
            checkValue("ready low cycles", lowCycles, 2);
        end
        checkValue("gameOver", gameOver, int'(refOver));
        checkValue("ready", ready, int'(!refOver));
        sweepBoard();
    endtask

    task automatic dropUntilLand();
        bit landed;
        int episodes;
        landed = 1'b0;
        episodes = 0;
        while (!landed && !gameOver && episodes < 25) begin
            dropEpisode(landed);
            episodes++;
        end
        if (!landed) reportProblem("piece did not land");
    endtask

    task automatic placePiece(int shift);
        int steps;
        steps = (shift < 0) ? -shift : shift;
        for (int i = 0; i < steps; i++) issueMove(shift < 0);
        dropUntilLand();
    endtask

    task automatic resetDut();
        rst_up = 1'b1;
        run = 1'b0;
        fastFall = 1'b0;
        moveLeft = 1'b0;
        moveRight = 1'b0;
        repeat (16) @(posedge clk);
        #1 rst_up = 1'b0;
        refReset();
    endtask

    task automatic finishTest(string name, int errorsBefore);
        int newErrors;
        newErrors = errorCount + sweepErrors - errorsBefore;
        testCount++;
        if (newErrors > 0) begin
            testsFailed++;
            $display("test %s: failed with %0d errors", name, newErrors);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    initial begin
        int errorsBefore;
        int shifts [6];
        bit left;
        clk = 1'b0;
        void'($urandom(54612));
        // I, T, O, S, Z, L placed so that the bottom row fills
        shifts = '{-2, 2, 5, 4, 3, -3};

        resetDut();
        errorsBefore = errorCount + sweepErrors;
        checkValue("ready", ready, 1);
        checkValue("gameOver", gameOver, 0);
        sweepBoard();
        finishTest("reset state", errorsBefore);

        // random walk, then hard against each wall
        errorsBefore = errorCount + sweepErrors;
        for (int i = 0; i < 40; i++) begin
            if (i < 16) begin
                left = 1'($urandom % 2);
            end else begin
                left = (i < 28);
            end
            issueMove(left);
        end
        finishTest("moves and walls", errorsBefore);

        errorsBefore = errorCount + sweepErrors;
        dropUntilLand();
        fastFall = 1'b1;
        dropUntilLand();
        fastFall = 1'b0;
        finishTest("gravity and landing", errorsBefore);

        resetDut();
        errorsBefore = errorCount + sweepErrors;
        for (int p = 0; p < 6; p++) placePiece(shifts[p]);
        if (refLines != 1) reportProblem("steered pieces did not complete a row");
        finishTest("row compaction", errorsBefore);

        resetDut();
        errorsBefore = errorCount + sweepErrors;
        fastFall = 1'b1;
        for (int p = 0; p < 40 && !refOver; p++) dropUntilLand();
        if (!refOver) reportProblem("stack never reached the spawn area");
        // moves and gravity must stay dead after game over
        run = 1'b1;
        for (int i = 0; i < 24; i++) begin
            moveLeft = i[0];
            moveRight = !i[0];
            @(posedge clk);
            #1 checkValue("gameOver", gameOver, 1);
            checkValue("ready", ready, 0);
        end
        moveLeft = 1'b0;
        moveRight = 1'b0;
        run = 1'b0;
        sweepBoard();
        finishTest("game over", errorsBefore);

        $display("tests %0d, failed %0d, checks %0d, errors %0d", testCount, testsFailed,
                 checkCount + sweepChecks, errorCount + sweepErrors);
        if (errorCount + sweepErrors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+tb
rtl/tetrisPkg.sv
rtl/gravityTimer.sv
rtl/pieceSequencer.sv
rtl/gameControl.sv
rtl/playfield.sv
rtl/tetrisTop.sv
tb/tetrisTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tetrisTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard tb/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
